// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_e;

    // synchronous causes, standard numbering
    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_INSTR_FAULT      = 5'd1,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_LOAD_FAULT       = 5'd5,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_STORE_FAULT      = 5'd7,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_M          = 5'd11
    } exception_e;

    typedef enum logic [4:0] {
        INT_M_SOFT  = 5'd3,
        INT_M_TIMER = 5'd7,
        INT_M_EXT   = 5'd11
    } interrupt_e;

    typedef enum logic [4:0] {
        CSR_SEL_NONE,
        CSR_SEL_MSTATUS,
        CSR_SEL_MSTATUSH,
        CSR_SEL_MISA,
        CSR_SEL_MTVEC,
        CSR_SEL_MCOUNTEREN,
        CSR_SEL_MSCRATCH,
        CSR_SEL_MEPC,
        CSR_SEL_MCAUSE,
        CSR_SEL_MTVAL,
        CSR_SEL_MCYCLE,
        CSR_SEL_MCYCLEH,
        CSR_SEL_MINSTRET,
        CSR_SEL_MINSTRETH,
        CSR_SEL_CYCLE,
        CSR_SEL_CYCLEH,
        CSR_SEL_INSTRET,
        CSR_SEL_INSTRETH
    } csr_sel_e;

    localparam logic [11:0] csr_cycle      = 12'hC00;
    localparam logic [11:0] csr_instret    = 12'hC02;
    localparam logic [11:0] csr_cycleh     = 12'hC80;
    localparam logic [11:0] csr_instreth   = 12'hC82;
    localparam logic [11:0] csr_mstatus    = 12'h300;
    localparam logic [11:0] csr_misa       = 12'h301;
    localparam logic [11:0] csr_mtvec      = 12'h305;
    localparam logic [11:0] csr_mcounteren = 12'h306;
    localparam logic [11:0] csr_mstatush   = 12'h310;
    localparam logic [11:0] csr_mscratch   = 12'h340;
    localparam logic [11:0] csr_mepc       = 12'h341;
    localparam logic [11:0] csr_mcause     = 12'h342;
    localparam logic [11:0] csr_mtval      = 12'h343;
    localparam logic [11:0] csr_mcycle     = 12'hB00;
    localparam logic [11:0] csr_minstret   = 12'hB02;
    localparam logic [11:0] csr_mcycleh    = 12'hB80;
    localparam logic [11:0] csr_minstreth  = 12'hB82;

    // mxl=1, extensions a, i, m, u
    localparam logic [xlen-1:0] misa_value = 32'h4010_1101;

endpackage

`default_nettype wire

// ==== csr_access.sv ====
`default_nettype none

module csr_access #(
    parameter int counter_w = 64
) (
    input  logic                      csr_en,
    input  logic                      csr_read,
    input  logic                      csr_write,
    input  logic                      mret,
    input  logic                      exception_valid,
    input  logic [11:0]               csr_id,
    input  csr_pkg::priv_e            priv,
    input  logic [2:0]                mcounteren,
    input  logic [csr_pkg::xlen-1:0]  trap_rdata,
    input  logic [csr_pkg::xlen-1:0]  counter_rdata,
    output csr_pkg::csr_sel_e         csr_sel,
    output logic                      csr_write_en,
    output logic                      legal_mret,
    output logic                      ex_csr_illegal_instr,
    output logic [csr_pkg::xlen-1:0]  csr_rdata
);

    logic m_mode;
    logic is_user_alias;
    logic legal_read;
    logic legal_write;

    // high halves need at least one bit above 31
    if (counter_w < 33 || counter_w > 64) begin : g_width_check
        $error("counter_w out of range 33..64");
    end

    always_comb begin
        case (csr_id)
            csr_pkg::csr_mstatus:    csr_sel = csr_pkg::CSR_SEL_MSTATUS;
            csr_pkg::csr_mstatush:   csr_sel = csr_pkg::CSR_SEL_MSTATUSH;
            csr_pkg::csr_misa:       csr_sel = csr_pkg::CSR_SEL_MISA;
            csr_pkg::csr_mtvec:      csr_sel = csr_pkg::CSR_SEL_MTVEC;
            csr_pkg::csr_mcounteren: csr_sel = csr_pkg::CSR_SEL_MCOUNTEREN;
            csr_pkg::csr_mscratch:   csr_sel = csr_pkg::CSR_SEL_MSCRATCH;
            csr_pkg::csr_mepc:       csr_sel = csr_pkg::CSR_SEL_MEPC;
            csr_pkg::csr_mcause:     csr_sel = csr_pkg::CSR_SEL_MCAUSE;
            csr_pkg::csr_mtval:      csr_sel = csr_pkg::CSR_SEL_MTVAL;
            csr_pkg::csr_mcycle:     csr_sel = csr_pkg::CSR_SEL_MCYCLE;
            csr_pkg::csr_mcycleh:    csr_sel = csr_pkg::CSR_SEL_MCYCLEH;
            csr_pkg::csr_minstret:   csr_sel = csr_pkg::CSR_SEL_MINSTRET;
            csr_pkg::csr_minstreth:  csr_sel = csr_pkg::CSR_SEL_MINSTRETH;
            csr_pkg::csr_cycle:      csr_sel = csr_pkg::CSR_SEL_CYCLE;
            csr_pkg::csr_cycleh:     csr_sel = csr_pkg::CSR_SEL_CYCLEH;
            csr_pkg::csr_instret:    csr_sel = csr_pkg::CSR_SEL_INSTRET;
            csr_pkg::csr_instreth:   csr_sel = csr_pkg::CSR_SEL_INSTRETH;
            default:                 csr_sel = csr_pkg::CSR_SEL_NONE;
        endcase
    end

    assign m_mode        = (priv == csr_pkg::PRIV_M);
    assign is_user_alias = csr_sel inside {csr_pkg::CSR_SEL_CYCLE, csr_pkg::CSR_SEL_CYCLEH,
                                           csr_pkg::CSR_SEL_INSTRET, csr_pkg::CSR_SEL_INSTRETH};

    always_comb begin
        if (m_mode) begin
            legal_read  = (csr_sel != csr_pkg::CSR_SEL_NONE);
            legal_write = (csr_sel != csr_pkg::CSR_SEL_NONE) && !is_user_alias;
        end else begin
            // user mode sees only the counters opened by mcounteren
            case (csr_sel)
                csr_pkg::CSR_SEL_CYCLE,
                csr_pkg::CSR_SEL_CYCLEH:   legal_read = mcounteren[0];
                csr_pkg::CSR_SEL_INSTRET,
                csr_pkg::CSR_SEL_INSTRETH: legal_read = mcounteren[2];
                default:                   legal_read = 1'b0;
            endcase
            legal_write = 1'b0;
        end
    end

    assign csr_write_en         = csr_en && csr_write && legal_write && !exception_valid;
    assign legal_mret           = csr_en && mret && m_mode;
    assign ex_csr_illegal_instr = csr_en && ((csr_read && !legal_read) ||
                                             (csr_write && !legal_write) ||
                                             (mret && !m_mode));

    always_comb begin
        case (csr_sel)
            csr_pkg::CSR_SEL_MISA:       csr_rdata = csr_pkg::misa_value;
            csr_pkg::CSR_SEL_MSTATUSH:   csr_rdata = '0;
            csr_pkg::CSR_SEL_MCOUNTEREN: csr_rdata = {{(csr_pkg::xlen-3){1'b0}}, mcounteren};
            csr_pkg::CSR_SEL_MCYCLE,
            csr_pkg::CSR_SEL_MCYCLEH,
            csr_pkg::CSR_SEL_MINSTRET,
            csr_pkg::CSR_SEL_MINSTRETH,
            csr_pkg::CSR_SEL_CYCLE,
            csr_pkg::CSR_SEL_CYCLEH,
            csr_pkg::CSR_SEL_INSTRET,
            csr_pkg::CSR_SEL_INSTRETH:   csr_rdata = counter_rdata;
            default:                     csr_rdata = trap_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_trap_regs.sv ====
`default_nettype none

module csr_trap_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  csr_pkg::csr_sel_e         csr_sel,
    input  logic                      csr_write_en,
    input  logic                      legal_mret,
    input  logic [csr_pkg::xlen-1:0]  csr_wdata,
    input  logic [csr_pkg::xlen-1:0]  pc,
    input  logic                      exception_valid,
    input  logic                      interrupt_valid,
    input  csr_pkg::exception_e       exception_cause,
    input  csr_pkg::interrupt_e       interrupt_cause,
    input  logic [csr_pkg::xlen-1:0]  exception_value,
    output csr_pkg::priv_e            priv,
    output logic                      cfg_mie,
    output logic [csr_pkg::xlen-1:0]  trap_rdata,
    output logic [csr_pkg::xlen-1:0]  pc_csr,
    output logic                      pc_csr_valid
);

    localparam int w = csr_pkg::xlen;

    logic                  trap_valid;
    logic                  mie;
    logic                  mpie;
    csr_pkg::priv_e        mpp;
    logic [w-3:0]          mtvec_base;
    csr_pkg::mtvec_mode_e  mtvec_mode;
    logic [w-1:0]          mscratch;
    logic [w-3:0]          mepc_base;
    logic [w-1:0]          mcause;
    logic [w-1:0]          mtval;
    logic                  valid_mpp;
    logic                  valid_mode;
    logic [w-3:0]          vector_offset;

    assign trap_valid = exception_valid || interrupt_valid;
    assign cfg_mie    = mie;
    assign valid_mpp  = (csr_wdata[12:11] == csr_pkg::PRIV_U) ||
                        (csr_wdata[12:11] == csr_pkg::PRIV_M);
    assign valid_mode = (csr_wdata[1:0] == csr_pkg::MTVEC_DIRECT) ||
                        (csr_wdata[1:0] == csr_pkg::MTVEC_VECTORED);

    // priv and mstatus, trap beats mret beats write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv <= csr_pkg::PRIV_M;
            mie  <= 1'b0;
            mpie <= 1'b1;
            mpp  <= csr_pkg::PRIV_U;
        end else if (trap_valid) begin
            priv <= csr_pkg::PRIV_M;
            mie  <= 1'b0;
            mpie <= mie;
            mpp  <= priv;
        end else if (legal_mret) begin
            priv <= mpp;
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= csr_pkg::PRIV_U;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MSTATUS) begin
            mie  <= csr_wdata[3];
            mpie <= csr_wdata[7];
            if (valid_mpp) begin
                mpp <= csr_pkg::priv_e'(csr_wdata[12:11]);
            end
        end
    end

    // base always taken, mode only when legal
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_base <= '0;
            mtvec_mode <= csr_pkg::MTVEC_DIRECT;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MTVEC) begin
            mtvec_base <= csr_wdata[w-1:2];
            if (valid_mode) begin
                mtvec_mode <= csr_pkg::mtvec_mode_e'(csr_wdata[1:0]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MSCRATCH) begin
            mscratch <= csr_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_base <= '0;
            mcause    <= '0;
            mtval     <= '0;
        end else if (trap_valid) begin
            mepc_base <= pc[w-1:2];
            if (interrupt_valid) begin
                mcause <= {1'b1, {(w-6){1'b0}}, interrupt_cause};
                mtval  <= '0;
            end else begin
                mcause <= {{(w-5){1'b0}}, exception_cause};
                mtval  <= exception_value;
            end
        end else if (csr_write_en) begin
            case (csr_sel)
                csr_pkg::CSR_SEL_MEPC:   mepc_base <= csr_wdata[w-1:2];
                csr_pkg::CSR_SEL_MCAUSE: mcause    <= csr_wdata;
                csr_pkg::CSR_SEL_MTVAL:  mtval     <= csr_wdata;
                default:                 ;
            endcase
        end
    end

    // vectored entry is base plus 4 * cause
    assign vector_offset = {{(w-7){1'b0}}, interrupt_cause};

    always_comb begin
        pc_csr_valid = trap_valid || legal_mret;
        if (trap_valid) begin
            if (mtvec_mode == csr_pkg::MTVEC_VECTORED && interrupt_valid) begin
                pc_csr = {mtvec_base + vector_offset, 2'b00};
            end else begin
                pc_csr = {mtvec_base, 2'b00};
            end
        end else if (legal_mret) begin
            pc_csr = {mepc_base, 2'b00};
        end else begin
            pc_csr = '0;
        end
    end

    always_comb begin
        case (csr_sel)
            csr_pkg::CSR_SEL_MSTATUS:
                trap_rdata = {19'b0, mpp, 3'b0, mpie, 3'b0, mie, 3'b0};
            csr_pkg::CSR_SEL_MTVEC:    trap_rdata = {mtvec_base, mtvec_mode};
            csr_pkg::CSR_SEL_MSCRATCH: trap_rdata = mscratch;
            csr_pkg::CSR_SEL_MEPC:     trap_rdata = {mepc_base, 2'b00};
            csr_pkg::CSR_SEL_MCAUSE:   trap_rdata = mcause;
            csr_pkg::CSR_SEL_MTVAL:    trap_rdata = mtval;
            default:                   trap_rdata = '0;
        endcase
    end

    // mpp only ever holds a supported mode, through traps and writes alike
    a_mpp_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mpp inside {csr_pkg::PRIV_U, csr_pkg::PRIV_M});

endmodule

`default_nettype wire

// ==== csr_counters.sv ====
`default_nettype none

module csr_counters #(
    parameter int counter_w = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  csr_pkg::csr_sel_e         csr_sel,
    input  logic                      csr_write_en,
    input  logic                      instr_done,
    input  logic                      exception_valid,
    input  logic [csr_pkg::xlen-1:0]  csr_wdata,
    output logic [csr_pkg::xlen-1:0]  counter_rdata,
    output logic [2:0]                mcounteren
);

    logic [counter_w-1:0] mcycle;
    logic [counter_w-1:0] minstret;
    logic [counter_w-1:0] mcycle_inc;
    logic [counter_w-1:0] minstret_nxt;
    logic [63:0]          mcycle_ext;
    logic [63:0]          minstret_ext;
    logic                 mcounteren_cy;
    logic                 mcounteren_ir;

    assign mcycle_inc   = mcycle + 1'b1;
    assign minstret_nxt = (instr_done && !exception_valid) ? minstret + 1'b1 : minstret;

    // a half write keeps the other half counting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MCYCLE) begin
            mcycle <= {mcycle_inc[counter_w-1:32], csr_wdata[31:0]};
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MCYCLEH) begin
            mcycle <= {csr_wdata[counter_w-33:0], mcycle_inc[31:0]};
        end else begin
            mcycle <= mcycle_inc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MINSTRET) begin
            minstret <= {minstret_nxt[counter_w-1:32], csr_wdata[31:0]};
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MINSTRETH) begin
            minstret <= {csr_wdata[counter_w-33:0], minstret_nxt[31:0]};
        end else begin
            minstret <= minstret_nxt;
        end
    end

    // no time counter, so its enable bit stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcounteren_cy <= 1'b0;
            mcounteren_ir <= 1'b0;
        end else if (csr_write_en && csr_sel == csr_pkg::CSR_SEL_MCOUNTEREN) begin
            mcounteren_cy <= csr_wdata[0];
            mcounteren_ir <= csr_wdata[2];
        end
    end

    assign mcounteren   = {mcounteren_ir, 1'b0, mcounteren_cy};
    assign mcycle_ext   = 64'(mcycle);
    assign minstret_ext = 64'(minstret);

    always_comb begin
        case (csr_sel)
            csr_pkg::CSR_SEL_MCYCLE,
            csr_pkg::CSR_SEL_CYCLE:     counter_rdata = mcycle_ext[31:0];
            csr_pkg::CSR_SEL_MCYCLEH,
            csr_pkg::CSR_SEL_CYCLEH:    counter_rdata = mcycle_ext[63:32];
            csr_pkg::CSR_SEL_MINSTRET,
            csr_pkg::CSR_SEL_INSTRET:   counter_rdata = minstret_ext[31:0];
            csr_pkg::CSR_SEL_MINSTRETH,
            csr_pkg::CSR_SEL_INSTRETH:  counter_rdata = minstret_ext[63:32];
            default:                    counter_rdata = '0;
        endcase
    end

    // a faulting instruction never retires
    a_no_retire_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        exception_valid && !(csr_write_en && csr_sel inside
            {csr_pkg::CSR_SEL_MINSTRET, csr_pkg::CSR_SEL_MINSTRETH}) |=> $stable(minstret));

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`default_nettype none

module csr_unit #(
    parameter int counter_w = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      csr_en,
    input  logic                      instr_done,
    input  logic [11:0]               csr_id,
    input  logic                      csr_read,
    input  logic                      csr_write,
    input  logic [csr_pkg::xlen-1:0]  csr_wdata,
    input  logic                      mret,
    input  logic [csr_pkg::xlen-1:0]  pc,
    input  logic                      exception_valid,
    input  csr_pkg::exception_e       exception_cause,
    input  logic [csr_pkg::xlen-1:0]  exception_value,
    input  logic                      interrupt_valid,
    input  csr_pkg::interrupt_e       interrupt_cause,
    output logic [csr_pkg::xlen-1:0]  csr_rdata,
    output logic                      pc_csr_valid,
    output logic [csr_pkg::xlen-1:0]  pc_csr,
    output csr_pkg::priv_e            priv,
    output logic                      cfg_mie,
    output logic                      ex_csr_illegal_instr
);

    csr_pkg::csr_sel_e         csr_sel;
    logic                      csr_write_en;
    logic                      legal_mret;
    logic [csr_pkg::xlen-1:0]  trap_rdata;
    logic [csr_pkg::xlen-1:0]  counter_rdata;
    logic [2:0]                mcounteren;

    csr_access #(
        .counter_w            (counter_w)
    ) u_access (
        .csr_en               (csr_en),
        .csr_read             (csr_read),
        .csr_write            (csr_write),
        .mret                 (mret),
        .exception_valid      (exception_valid),
        .csr_id               (csr_id),
        .priv                 (priv),
        .mcounteren           (mcounteren),
        .trap_rdata           (trap_rdata),
        .counter_rdata        (counter_rdata),
        .csr_sel              (csr_sel),
        .csr_write_en         (csr_write_en),
        .legal_mret           (legal_mret),
        .ex_csr_illegal_instr (ex_csr_illegal_instr),
        .csr_rdata            (csr_rdata)
    );

    csr_trap_regs u_trap_regs (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_sel              (csr_sel),
        .csr_write_en         (csr_write_en),
        .legal_mret           (legal_mret),
        .csr_wdata            (csr_wdata),
        .pc                   (pc),
        .exception_valid      (exception_valid),
        .interrupt_valid      (interrupt_valid),
        .exception_cause      (exception_cause),
        .interrupt_cause      (interrupt_cause),
        .exception_value      (exception_value),
        .priv                 (priv),
        .cfg_mie              (cfg_mie),
        .trap_rdata           (trap_rdata),
        .pc_csr               (pc_csr),
        .pc_csr_valid         (pc_csr_valid)
    );

    csr_counters #(
        .counter_w            (counter_w)
    ) u_counters (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_sel              (csr_sel),
        .csr_write_en         (csr_write_en),
        .instr_done           (instr_done),
        .exception_valid      (exception_valid),
        .csr_wdata            (csr_wdata),
        .counter_rdata        (counter_rdata),
        .mcounteren           (mcounteren)
    );

endmodule

`default_nettype wire

// ==== tb_csr_check.svh ====
`ifndef TB_CSR_CHECK_SVH
`define TB_CSR_CHECK_SVH

task automatic stop_on_error(string why);
    $display("%s", why);
    error_count = error_count + 1;
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_value(string test_name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
        stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", test_name, exp, act));
    end
endtask

task automatic drive_idle();
    csr_en          = 1'b0;
    instr_done      = 1'b0;
    csr_id          = 12'h000;
    csr_read        = 1'b0;
    csr_write       = 1'b0;
    csr_wdata       = 32'h0;
    mret            = 1'b0;
    pc              = 32'h0;
    exception_valid = 1'b0;
    exception_cause = csr_pkg::EXC_INSTR_MISALIGNED;
    exception_value = 32'h0;
    interrupt_valid = 1'b0;
    interrupt_cause = csr_pkg::interrupt_e'(5'd0);
endtask

// read data only matters when the access is legal
task automatic read_csr(int i);
    @(posedge clk);
    #2;
    drive_idle();
    csr_en   = 1'b1;
    csr_read = 1'b1;
    csr_id   = csr_q[i][11:0];
    @(negedge clk);
    check_value(name_q[i], aux_q[i], {31'b0, ex_csr_illegal_instr});
    if (aux_q[i] == 32'h0) begin
        check_value(name_q[i], exp_q[i], csr_rdata);
    end
endtask

task automatic write_csr(int i);
    @(posedge clk);
    #2;
    drive_idle();
    csr_en    = 1'b1;
    csr_write = 1'b1;
    csr_id    = csr_q[i][11:0];
    csr_wdata = wdata_q[i];
    @(negedge clk);
    check_value(name_q[i], aux_q[i], {31'b0, ex_csr_illegal_instr});
endtask

// aux picks interrupt over exception
task automatic take_trap(int i);
    @(posedge clk);
    #2;
    drive_idle();
    pc = pc_q[i];
    if (aux_q[i] == 32'h0) begin
        exception_valid = 1'b1;
        exception_cause = csr_pkg::exception_e'(cause_q[i][4:0]);
        exception_value = wdata_q[i];
    end else begin
        interrupt_valid = 1'b1;
        interrupt_cause = csr_pkg::interrupt_e'(cause_q[i][4:0]);
    end
    @(negedge clk);
    check_value(name_q[i], 32'h1, {31'b0, pc_csr_valid});
    check_value(name_q[i], exp_q[i], pc_csr);
endtask

task automatic issue_mret(int i);
    @(posedge clk);
    #2;
    drive_idle();
    csr_en = 1'b1;
    mret   = 1'b1;
    @(negedge clk);
    check_value(name_q[i], aux_q[i], {31'b0, ex_csr_illegal_instr});
    check_value(name_q[i], {31'b0, aux_q[i] == 32'h0}, {31'b0, pc_csr_valid});
    if (aux_q[i] == 32'h0) begin
        check_value(name_q[i], exp_q[i], pc_csr);
    end
endtask

task automatic check_status(int i);
    @(posedge clk);
    #2;
    drive_idle();
    @(negedge clk);
    check_value(name_q[i], exp_q[i], {29'b0, cfg_mie, priv});
endtask

// a retire with aux set also faults, so it traps
task automatic retire_instr(int i);
    @(posedge clk);
    #2;
    drive_idle();
    instr_done      = 1'b1;
    exception_valid = aux_q[i][0];
    exception_cause = csr_pkg::exception_e'(cause_q[i][4:0]);
    pc              = pc_q[i];
    @(negedge clk);
    check_value(name_q[i], aux_q[i], {31'b0, pc_csr_valid});
endtask

task automatic idle_cycles(int n);
    repeat (n) begin
        @(posedge clk);
        #2;
        drive_idle();
    end
endtask

`endif

// ==== tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit;

    logic                  clk;
    logic                  rst_n;
    logic                  csr_en;
    logic                  instr_done;
    logic [11:0]           csr_id;
    logic                  csr_read;
    logic                  csr_write;
    logic [31:0]           csr_wdata;
    logic                  mret;
    logic [31:0]           pc;
    logic                  exception_valid;
    csr_pkg::exception_e   exception_cause;
    logic [31:0]           exception_value;
    logic                  interrupt_valid;
    csr_pkg::interrupt_e   interrupt_cause;
    logic [31:0]           csr_rdata;
    logic                  pc_csr_valid;
    logic [31:0]           pc_csr;
    csr_pkg::priv_e        priv;
    logic                  cfg_mie;
    logic                  ex_csr_illegal_instr;

    // one entry per golden line
    string                 name_q[$];
    string                 op_q[$];
    logic [31:0]           csr_q[$];
    logic [31:0]           wdata_q[$];
    logic [31:0]           pc_q[$];
    logic [31:0]           cause_q[$];
    logic [31:0]           aux_q[$];
    logic [31:0]           exp_q[$];
    int                    error_count;
    int                    cycle_count;
    int                    cycle_limit;

    `include "tb_csr_check.svh"

    csr_unit #(
        .counter_w            (64)
    ) dut0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_en               (csr_en),
        .instr_done           (instr_done),
        .csr_id               (csr_id),
        .csr_read             (csr_read),
        .csr_write            (csr_write),
        .csr_wdata            (csr_wdata),
        .mret                 (mret),
        .pc                   (pc),
        .exception_valid      (exception_valid),
        .exception_cause      (exception_cause),
        .exception_value      (exception_value),
        .interrupt_valid      (interrupt_valid),
        .interrupt_cause      (interrupt_cause),
        .csr_rdata            (csr_rdata),
        .pc_csr_valid         (pc_csr_valid),
        .pc_csr               (pc_csr),
        .priv                 (priv),
        .cfg_mie              (cfg_mie),
        .ex_csr_illegal_instr (ex_csr_illegal_instr)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_on_error($sformatf("timeout: golden run still busy after %0d cycles",
                                    cycle_count));
        end
    end

    // comment lines start with #
    task automatic load_golden();
        int          fd;
        int          code;
        int          idle_sum;
        string       name;
        string       op;
        string       rest;
        logic [31:0] f_csr;
        logic [31:0] f_wdata;
        logic [31:0] f_pc;
        logic [31:0] f_cause;
        logic [31:0] f_aux;
        logic [31:0] f_exp;
        idle_sum = 0;
        fd = $fopen("csr_golden.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open csr_golden.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", name);
                if (code == 1 && name.getc(0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h", op, f_csr, f_wdata, f_pc,
                                   f_cause, f_aux, f_exp);
                    if (code != 7) begin
                        stop_on_error($sformatf("golden line %s is missing fields", name));
                    end
                    name_q.push_back(name);
                    op_q.push_back(op);
                    csr_q.push_back(f_csr);
                    wdata_q.push_back(f_wdata);
                    pc_q.push_back(f_pc);
                    cause_q.push_back(f_cause);
                    aux_q.push_back(f_aux);
                    exp_q.push_back(f_exp);
                    if (op == "idle") begin
                        idle_sum = idle_sum + int'(f_aux);
                    end
                end
            end
            $fclose(fd);
            cycle_limit = name_q.size() + idle_sum + 64;
        end
    endtask

    task automatic run_step(int i);
        if (op_q[i] == "read") begin
            read_csr(i);
        end else if (op_q[i] == "write") begin
            write_csr(i);
        end else if (op_q[i] == "trap") begin
            take_trap(i);
        end else if (op_q[i] == "mret") begin
            issue_mret(i);
        end else if (op_q[i] == "status") begin
            check_status(i);
        end else if (op_q[i] == "retire") begin
            retire_instr(i);
        end else if (op_q[i] == "idle") begin
            idle_cycles(int'(aux_q[i]));
        end else begin
            stop_on_error($sformatf("golden line %s has an unknown operation %s",
                                    name_q[i], op_q[i]));
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        drive_idle();
        load_golden();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (op_q[i]) begin
            run_step(i);
        end
        @(posedge clk);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_golden.txt ====
# name op csr wdata pc cause aux expect, numbers in hex
# aux: illegal flag for read/write/mret, interrupt flag for trap, exception for retire, idle count
rst_mstatus read 300 0 0 0 0 80
rst_misa read 301 0 0 0 0 40101101
rst_mtvec read 305 0 0 0 0 0
rst_mepc read 341 0 0 0 0 0
rst_mscratch read 340 0 0 0 0 0
rst_status status 0 0 0 0 0 3
wr_mscratch write 340 a5a5c3c3 0 0 0 0
rd_mscratch read 340 0 0 0 0 a5a5c3c3
wr_mepc write 341 12345677 0 0 0 0
rd_mepc read 341 0 0 0 0 12345674
wr_mtvec_vec write 305 1001 0 0 0 0
wr_mtvec_mode3 write 305 2003 0 0 0 0
rd_mtvec read 305 0 0 0 0 2001
wr_mpp_one write 300 888 0 0 0 0
rd_mpp_kept read 300 0 0 0 0 88
rd_mvendorid read f11 0 0 0 1 0
trap_exc trap 0 dead0bad 404 2 0 2000
rd_mepc_exc read 341 0 0 0 0 404
rd_mcause_exc read 342 0 0 0 0 2
rd_mtval_exc read 343 0 0 0 0 dead0bad
rd_mstatus_exc read 300 0 0 0 0 1880
trap_irq trap 0 0 812 7 1 201c
rd_mcause_irq read 342 0 0 0 0 80000007
rd_mtval_irq read 343 0 0 0 0 0
rd_mstatus_irq read 300 0 0 0 0 1800
wr_mstatus_u write 300 80 0 0 0 0
wr_mepc_ret write 341 3000 0 0 0 0
mret_to_u mret 0 0 0 0 0 3000
u_status status 0 0 0 0 0 4
u_write write 340 1 0 0 1 0
u_mret mret 0 0 0 0 1 0
u_cycle_off read c00 0 0 0 1 0
trap_ecall_u trap 0 0 3000 8 0 2000
wr_mcounteren write 306 1 0 0 0 0
wr_mcycle_u write b00 1000 0 0 0 0
mret_again mret 0 0 0 0 0 3000
u_cycle_on read c00 0 0 0 0 1001
trap_to_m trap 0 0 3004 8 0 2000
wr_mcycle write b00 1000 0 0 0 0
idle_five idle 0 0 0 0 5 0
rd_mcycle read b00 0 0 0 0 1005
wr_mcycleh write b80 abcd 0 0 0 0
rd_mcycleh read b80 0 0 0 0 abcd
retire_one retire 0 0 0 0 0 0
retire_exc retire 0 0 500 2 1 0
retire_two retire 0 0 0 0 0 0
rd_minstret read b02 0 0 0 0 2

// ==== files.f ====
+incdir+.
csr_pkg.sv
csr_access.sv
csr_trap_regs.sv
csr_counters.sv
csr_unit.sv
tb_csr_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass message in the output
verilator --binary --assert -Wno-fatal --top-module tb_csr_unit -f files.f -o sim_csr \
    && ./obj_dir/sim_csr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
